// ==== source/execPkg.sv ====
// =========================================================================
// Shared constants for the execute subsystem
// All sizes are fixed here, no module carries parameters
// Instruction word: opcode 7..0, Rt 11..8, Ra 15..12, Rb 19..16 and a
// signed 12-bit immediate at 31..20
// =========================================================================

package execPkg;

	localparam int dataWidth   = 32;
	localparam int regCount    = 16;
	localparam int regIdxWidth = 4;
	localparam int instrWidth  = 32;
	localparam int opWidth     = 8;
	localparam int immWidth    = 12;
	localparam int addrWidth   = 8;
	// Bit number width for BMS and BMC
	localparam int bitIdxWidth = 5;

	// Opcodes
	localparam logic [opWidth-1:0] opAdd    = 8'h01;
	localparam logic [opWidth-1:0] opSub    = 8'h02;
	localparam logic [opWidth-1:0] opAnd    = 8'h03;
	localparam logic [opWidth-1:0] opOr     = 8'h04;
	localparam logic [opWidth-1:0] opEor    = 8'h05;
	localparam logic [opWidth-1:0] opAsl    = 8'h10;
	localparam logic [opWidth-1:0] opLsr    = 8'h11;
	localparam logic [opWidth-1:0] opRol    = 8'h12;
	localparam logic [opWidth-1:0] opRor    = 8'h13;
	localparam logic [opWidth-1:0] opInc    = 8'h14;
	localparam logic [opWidth-1:0] opDec    = 8'h15;
	localparam logic [opWidth-1:0] opAddImm = 8'h20;
	localparam logic [opWidth-1:0] opSubImm = 8'h21;
	localparam logic [opWidth-1:0] opLdImm  = 8'h22;
	localparam logic [opWidth-1:0] opBms    = 8'h30;
	localparam logic [opWidth-1:0] opBmc    = 8'h31;
	localparam logic [opWidth-1:0] opCmp    = 8'h32;
	localparam logic [opWidth-1:0] opTsr    = 8'h33;

	// APB address map, registers sit at 0x40 + 4 * index
	localparam logic [addrWidth-1:0] addrInstr   = 8'h00;
	localparam logic [addrWidth-1:0] addrResult  = 8'h04;
	localparam logic [addrWidth-1:0] addrFlags   = 8'h08;
	localparam logic [addrWidth-1:0] addrCtrl    = 8'h0C;
	localparam logic [addrWidth-1:0] addrRegBase = 8'h40;
	localparam logic [addrWidth-1:0] regWinMask  = 8'hC3;

	// Flag word layout
	localparam int flagC     = 0;
	localparam int flagZ     = 1;
	localparam int flagN     = 2;
	localparam int flagV     = 3;
	localparam int flagIll   = 4;
	localparam int flagCount = 5;

endpackage

// ==== source/aluCore.sv ====
// =========================================================================
// Combinational ALU, zero latency
// res bit 32 carries the carry, borrow or the bit shifted out
// With carryEnable low ADD ignores carry and SUB ignores borrow
// CMP never takes the borrow and never writes a register
// Unknown opcodes return zero with illegal high
// =========================================================================
`timescale 1ns/1ps

module aluCore
(
	input  logic [execPkg::opWidth-1:0]   opcode,
	input  logic [execPkg::immWidth-1:0]  imm,
	input  logic [execPkg::dataWidth-1:0] rfoa,
	input  logic [execPkg::dataWidth-1:0] rfob,
	input  logic                          carryIn,
	input  logic                          carryEnable,
	input  logic [execPkg::flagCount-1:0] flags,
	output logic [execPkg::dataWidth:0]   res,
	output logic                          resWrite,
	output logic                          illegal,
	output logic                          setZn,
	output logic                          setC,
	output logic                          setV,
	output logic                          overflow
);

	logic [execPkg::dataWidth-1:0] immExt;
	logic [execPkg::dataWidth-1:0] opB;
	logic                          useImm;
	logic                          carryAdd;
	logic                          borrowSub;
	logic [execPkg::dataWidth:0]   sum;
	logic [execPkg::dataWidth:0]   diff;
	logic [execPkg::dataWidth-1:0] bitMask;
	logic                          addOvf;
	logic                          subOvf;

	assign immExt = {{(execPkg::dataWidth-execPkg::immWidth){imm[execPkg::immWidth-1]}}, imm};

	assign useImm = (opcode == execPkg::opAddImm) || (opcode == execPkg::opSubImm);
	assign opB    = useImm ? immExt : rfob;

	// The carry chain takes part only in add-with-carry mode
	assign carryAdd  = carryEnable & carryIn;
	assign borrowSub = carryEnable & ~carryIn & (opcode != execPkg::opCmp);

	assign sum  = {1'b0, rfoa} + {1'b0, opB} + (execPkg::dataWidth+1)'(carryAdd);
	assign diff = {1'b0, rfoa} - {1'b0, opB} - (execPkg::dataWidth+1)'(borrowSub);

	// Signed overflow from the operand and result sign bits
	assign addOvf = (rfoa[execPkg::dataWidth-1] == opB[execPkg::dataWidth-1]) &&
		(sum[execPkg::dataWidth-1] != rfoa[execPkg::dataWidth-1]);
	assign subOvf = (rfoa[execPkg::dataWidth-1] != opB[execPkg::dataWidth-1]) &&
		(diff[execPkg::dataWidth-1] != rfoa[execPkg::dataWidth-1]);

	assign bitMask = execPkg::dataWidth'(1) << rfob[execPkg::bitIdxWidth-1:0];

	always_comb
	begin
		res      = '0;
		resWrite = 1'b1;
		illegal  = 1'b0;
		setZn    = 1'b1;
		setC     = 1'b0;
		setV     = 1'b0;
		overflow = 1'b0;
		case (opcode)
			// =============================================================
			// Arithmetic
			// =============================================================
			execPkg::opAdd, execPkg::opAddImm:
			begin
				res      = sum;
				setC     = 1'b1;
				setV     = 1'b1;
				overflow = addOvf;
			end
			execPkg::opSub, execPkg::opSubImm:
			begin
				res      = diff;
				setC     = 1'b1;
				setV     = 1'b1;
				overflow = subOvf;
			end
			execPkg::opCmp:
			begin
				res      = diff;
				resWrite = 1'b0;
				setC     = 1'b1;
				setV     = 1'b1;
				overflow = subOvf;
			end
			execPkg::opInc:
			begin
				res  = {1'b0, rfoa} + (execPkg::dataWidth+1)'(1);
				setC = 1'b1;
			end
			execPkg::opDec:
			begin
				res  = {1'b0, rfoa} - (execPkg::dataWidth+1)'(1);
				setC = 1'b1;
			end
			// =============================================================
			// Logic, shifts and bit operations
			// =============================================================
			execPkg::opAnd: res = {1'b0, rfoa & rfob};
			execPkg::opOr:  res = {1'b0, rfoa | rfob};
			execPkg::opEor: res = {1'b0, rfoa ^ rfob};
			execPkg::opAsl:
			begin
				res  = {rfoa, 1'b0};
				setC = 1'b1;
			end
			execPkg::opLsr:
			begin
				res  = {rfoa[0], 1'b0, rfoa[execPkg::dataWidth-1:1]};
				setC = 1'b1;
			end
			// Rotates run through the carry flag
			execPkg::opRol:
			begin
				res  = {rfoa, carryIn};
				setC = 1'b1;
			end
			execPkg::opRor:
			begin
				res  = {rfoa[0], carryIn, rfoa[execPkg::dataWidth-1:1]};
				setC = 1'b1;
			end
			execPkg::opLdImm: res = {1'b0, immExt};
			execPkg::opBms:   res = {1'b0, rfoa | bitMask};
			execPkg::opBmc:   res = {1'b0, rfoa & ~bitMask};
			execPkg::opTsr:
			begin
				res   = {{(execPkg::dataWidth+1-execPkg::flagCount){1'b0}}, flags};
				setZn = 1'b0;
			end
			default:
			begin
				resWrite = 1'b0;
				illegal  = 1'b1;
				setZn    = 1'b0;
			end
		endcase
	end

endmodule

// ==== source/registerFile.sv ====
// =========================================================================
// Sixteen 32-bit registers, all cleared by reset
// Two combinational read ports feed the ALU, a third serves APB
// Write-back wins over an APB write in the same cycle
// =========================================================================
`timescale 1ns/1ps

module registerFile
(
	input  logic                            clk,
	input  logic                            arstN,
	input  logic [execPkg::regIdxWidth-1:0] ra,
	input  logic [execPkg::regIdxWidth-1:0] rb,
	input  logic [execPkg::regIdxWidth-1:0] wbIdx,
	input  logic [execPkg::dataWidth-1:0]   wbData,
	input  logic                            wbEn,
	input  logic [execPkg::regIdxWidth-1:0] regAddr,
	input  logic [execPkg::dataWidth-1:0]   regWrData,
	input  logic                            regWrEn,
	output logic [execPkg::dataWidth-1:0]   rfoa,
	output logic [execPkg::dataWidth-1:0]   rfob,
	output logic [execPkg::dataWidth-1:0]   regRdData
);

	logic [execPkg::dataWidth-1:0] regs [execPkg::regCount];

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < execPkg::regCount; i++)
				regs[i] <= '0;
		end
		else if (wbEn)
			regs[wbIdx] <= wbData;
		else if (regWrEn)
			regs[regAddr] <= regWrData;
	end

	assign rfoa      = regs[ra];
	assign rfob      = regs[rb];
	assign regRdData = regs[regAddr];

	// Write-back falls in the APB setup phase, host writes only in the access phase
	wbApbExclusive: assert property (@(posedge clk) disable iff (!arstN)
		!(wbEn && regWrEn));

endmodule

// ==== source/flagUnit.sv ====
// =========================================================================
// Carry, zero, negative, overflow and illegal-opcode flags
// Each flag moves only when its set strobe is high during update
// The illegal flag stays set until the host clears the flag word
// =========================================================================
`timescale 1ns/1ps

module flagUnit
(
	input  logic                          clk,
	input  logic                          arstN,
	input  logic                          update,
	input  logic [execPkg::dataWidth:0]   res,
	input  logic                          setZn,
	input  logic                          setC,
	input  logic                          setV,
	input  logic                          overflow,
	input  logic                          illegal,
	input  logic                          clear,
	output logic [execPkg::flagCount-1:0] flags,
	output logic                          carry
);

	logic [execPkg::flagCount-1:0] flagQ;

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			flagQ <= '0;
		else if (clear)
			flagQ <= '0;
		else if (update)
		begin
			if (setZn)
			begin
				flagQ[execPkg::flagZ] <= ~|res[execPkg::dataWidth-1:0];
				flagQ[execPkg::flagN] <= res[execPkg::dataWidth-1];
			end
			if (setC)
				flagQ[execPkg::flagC] <= res[execPkg::dataWidth];
			if (setV)
				flagQ[execPkg::flagV] <= overflow;
			// Sticky
			if (illegal)
				flagQ[execPkg::flagIll] <= 1'b1;
		end
	end

	assign flags = flagQ;
	assign carry = flagQ[execPkg::flagC];

	// A clear comes from an APB access phase, an update from the cycle after one
	clearUpdateExclusive: assert property (@(posedge clk) disable iff (!arstN)
		!(clear && update));

endmodule

// ==== source/apbExecUnit.sv ====
// =========================================================================
// APB slave of the execute subsystem, no wait states
// A write to the instruction address raises execValid for the next cycle
// pslverr is registered in the setup phase and shows in the access phase
// Errors: unmapped or misaligned address, write to the result register
// =========================================================================
`timescale 1ns/1ps

module apbExecUnit
(
	input  logic                            clk,
	input  logic                            arstN,
	input  logic                            psel,
	input  logic                            penable,
	input  logic                            pwrite,
	input  logic [execPkg::addrWidth-1:0]   paddr,
	input  logic [execPkg::dataWidth-1:0]   pwdata,
	output logic [execPkg::dataWidth-1:0]   prdata,
	output logic                            pready,
	output logic                            pslverr,
	output logic [execPkg::opWidth-1:0]     opcode,
	output logic [execPkg::regIdxWidth-1:0] rt,
	output logic [execPkg::regIdxWidth-1:0] ra,
	output logic [execPkg::regIdxWidth-1:0] rb,
	output logic [execPkg::immWidth-1:0]    imm,
	output logic                            execValid,
	output logic                            carryEnable,
	output logic [execPkg::regIdxWidth-1:0] regAddr,
	output logic [execPkg::dataWidth-1:0]   regWrData,
	output logic                            regWrEn,
	input  logic [execPkg::dataWidth-1:0]   regRdData,
	input  logic [execPkg::dataWidth-1:0]   res,
	input  logic [execPkg::flagCount-1:0]   flags,
	output logic                            flagClear
);

	logic [execPkg::instrWidth-1:0] instrQ;
	logic [execPkg::dataWidth-1:0]  resultQ;
	logic isInstr;
	logic isResult;
	logic isFlags;
	logic isCtrl;
	logic isReg;
	logic accessErr;
	logic wrAccess;

	// =====================================================================
	// Address decode
	// =====================================================================
	assign isInstr  = paddr == execPkg::addrInstr;
	assign isResult = paddr == execPkg::addrResult;
	assign isFlags  = paddr == execPkg::addrFlags;
	assign isCtrl   = paddr == execPkg::addrCtrl;
	assign isReg    = (paddr & execPkg::regWinMask) == execPkg::addrRegBase;

	assign accessErr = !(isInstr || isResult || isFlags || isCtrl || isReg) ||
		(pwrite && isResult);

	assign wrAccess = psel && penable && pwrite && !accessErr;

	assign pready = 1'b1;

	// =====================================================================
	// Control registers
	// =====================================================================
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			instrQ      <= '0;
			resultQ     <= '0;
			execValid   <= 1'b0;
			carryEnable <= 1'b0;
			pslverr     <= 1'b0;
		end
		else
		begin
			execValid <= wrAccess && isInstr;
			pslverr   <= psel && !penable && accessErr;
			if (wrAccess && isInstr)
				instrQ <= pwdata;
			if (wrAccess && isCtrl)
				carryEnable <= pwdata[0];
			// The result register follows every executed instruction
			if (execValid)
				resultQ <= res;
		end
	end

	// Instruction fields stay valid after the execute cycle
	assign opcode = instrQ[7:0];
	assign rt     = instrQ[11:8];
	assign ra     = instrQ[15:12];
	assign rb     = instrQ[19:16];
	assign imm    = instrQ[31:20];

	assign regAddr   = paddr[execPkg::regIdxWidth+1:2];
	assign regWrData = pwdata;
	assign regWrEn   = wrAccess && isReg;
	assign flagClear = wrAccess && isFlags;

	// Read data mux
	always_comb
	begin
		prdata = '0;
		if (isReg)
			prdata = regRdData;
		else
		begin
			case (paddr)
				execPkg::addrInstr:  prdata = instrQ;
				execPkg::addrResult: prdata = resultQ;
				execPkg::addrFlags:
					prdata = {{(execPkg::dataWidth-execPkg::flagCount){1'b0}}, flags};
				execPkg::addrCtrl:
					prdata = {{(execPkg::dataWidth-1){1'b0}}, carryEnable};
				default: prdata = '0;
			endcase
		end
	end

	// The registered error must line up with the access phase
	slverrInAccess: assert property (@(posedge clk) disable iff (!arstN)
		pslverr |-> psel && penable);

	execValidSingle: assert property (@(posedge clk) disable iff (!arstN)
		execValid |=> !execValid);

endmodule

// ==== source/execTop.sv ====
// =========================================================================
// Top level of the execute subsystem with an APB port only
// One instruction executes in the cycle after its APB write
// =========================================================================
`timescale 1ns/1ps

module execTop
(
	input  logic                          clk,
	input  logic                          arstN,
	input  logic                          psel,
	input  logic                          penable,
	input  logic                          pwrite,
	input  logic [execPkg::addrWidth-1:0] paddr,
	input  logic [execPkg::dataWidth-1:0] pwdata,
	output logic [execPkg::dataWidth-1:0] prdata,
	output logic                          pready,
	output logic                          pslverr
);

	logic [execPkg::opWidth-1:0]     opcode;
	logic [execPkg::regIdxWidth-1:0] rt;
	logic [execPkg::regIdxWidth-1:0] ra;
	logic [execPkg::regIdxWidth-1:0] rb;
	logic [execPkg::immWidth-1:0]    imm;
	logic                            execValid;
	logic                            carryEnable;
	logic [execPkg::regIdxWidth-1:0] regAddr;
	logic [execPkg::dataWidth-1:0]   regWrData;
	logic                            regWrEn;
	logic [execPkg::dataWidth-1:0]   regRdData;
	logic [execPkg::dataWidth-1:0]   rfoa;
	logic [execPkg::dataWidth-1:0]   rfob;
	logic [execPkg::dataWidth:0]     res;
	logic                            resWrite;
	logic                            illegal;
	logic                            setZn;
	logic                            setC;
	logic                            setV;
	logic                            overflow;
	logic [execPkg::flagCount-1:0]   flags;
	logic                            carry;
	logic                            flagClear;
	logic                            wbEn;
	logic                            flagUpdate;

	// Strobes for write-back and the flag update
	assign wbEn       = execValid && resWrite;
	assign flagUpdate = execValid && (setZn || setC || setV || illegal);

	apbExecUnit apbExecUnit_inst
	(
		.clk(clk), .arstN(arstN), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .opcode(opcode), .rt(rt), .ra(ra), .rb(rb), .imm(imm),
		.execValid(execValid), .carryEnable(carryEnable), .regAddr(regAddr),
		.regWrData(regWrData), .regWrEn(regWrEn), .regRdData(regRdData),
		.res(res[execPkg::dataWidth-1:0]), .flags(flags), .flagClear(flagClear)
	);

	registerFile registerFile_inst
	(
		.clk(clk), .arstN(arstN), .ra(ra), .rb(rb), .wbIdx(rt),
		.wbData(res[execPkg::dataWidth-1:0]), .wbEn(wbEn), .regAddr(regAddr),
		.regWrData(regWrData), .regWrEn(regWrEn), .rfoa(rfoa), .rfob(rfob),
		.regRdData(regRdData)
	);

	flagUnit flagUnit_inst
	(
		.clk(clk), .arstN(arstN), .update(flagUpdate), .res(res), .setZn(setZn),
		.setC(setC), .setV(setV), .overflow(overflow), .illegal(illegal),
		.clear(flagClear), .flags(flags), .carry(carry)
	);

	aluCore aluCore_inst
	(
		.opcode(opcode), .imm(imm), .rfoa(rfoa), .rfob(rfob), .carryIn(carry),
		.carryEnable(carryEnable), .flags(flags), .res(res), .resWrite(resWrite),
		.illegal(illegal), .setZn(setZn), .setC(setC), .setV(setV),
		.overflow(overflow)
	);

endmodule

// ==== test/execTb.sv ====
// ==========================================================================
// Testbench for the execute subsystem, driven over APB only
// Every test comes from test/exec_golden.dat, one line per test
// Run from the project root so that the data file path resolves
// Register contents are tracked in a shadow copy built from host writes
// and expected results, and must start at zero after reset
// ==========================================================================
`timescale 1ns/1ps

module execTb;

	localparam int clkPeriod = 40;
	localparam int resetCycles = 8;
	localparam int cyclesPerTest = 20;
	localparam int spareCycles = 100;
	localparam string goldenPath = "test/exec_golden.dat";

	// One golden line. For kinds e and r the address sits in aVal
	typedef struct
	{
		logic [7:0]                    kind;
		string                         name;
		logic [execPkg::dataWidth-1:0] ctrl;
		logic [execPkg::dataWidth-1:0] aVal;
		logic [execPkg::dataWidth-1:0] bVal;
		logic [execPkg::dataWidth-1:0] instr;
		logic [execPkg::dataWidth-1:0] expWord;
		logic [execPkg::flagCount-1:0] expFlags;
	} goldenLine;

	logic                          clk;
	logic                          arstN;
	logic                          psel;
	logic                          penable;
	logic                          pwrite;
	logic [execPkg::addrWidth-1:0] paddr;
	logic [execPkg::dataWidth-1:0] pwdata;
	logic [execPkg::dataWidth-1:0] prdata;
	logic                          pready;
	logic                          pslverr;

	logic [execPkg::dataWidth-1:0] shadowRegs [execPkg::regCount];
	goldenLine tests [$];
	int errorCount = 0;
	int checkCount = 0;
	int watchdogCycles = 0;

	always #(clkPeriod / 2) clk = ~clk;

	execTop execTop_inst
	(
		.clk(clk), .arstN(arstN), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr)
	);

	// ======================================================================
	// Compare tasks
	// ======================================================================
	task automatic checkWord(input string testName, input string what,
		input logic [execPkg::dataWidth-1:0] expected,
		input logic [execPkg::dataWidth-1:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("mismatch %s %s expected %08h actual %08h", testName, what,
				expected, actual);
		end
	endtask

	task automatic checkFlags(input string testName,
		input logic [execPkg::flagCount-1:0] expected,
		input logic [execPkg::flagCount-1:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("mismatch %s flags expected %02h actual %02h", testName, expected, actual);
		end
	endtask

	task automatic checkErr(input string testName, input logic expected, input logic actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("mismatch %s pslverr expected %0b actual %0b", testName, expected, actual);
		end
	endtask

	// The slave has no wait states, so pready must be high in every access phase
	task automatic checkReady(input logic [execPkg::addrWidth-1:0] addr);
		checkCount++;
		if (pready !== 1'b1)
		begin
			errorCount++;
			$display("pready was low in the access phase at address %02h", addr);
		end
	endtask

	// ======================================================================
	// APB transfers take two cycles each with no idle between them
	// ======================================================================
	task automatic apbWrite(input logic [execPkg::addrWidth-1:0] addr,
		input logic [execPkg::dataWidth-1:0] data, output logic err);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;
		#(clkPeriod / 4);
		err = pslverr;
		checkReady(addr);
		@(posedge clk);
	endtask

	task automatic apbRead(input logic [execPkg::addrWidth-1:0] addr,
		output logic [execPkg::dataWidth-1:0] data, output logic err);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge clk);
		penable = 1'b1;
		// Sample in the middle of the access phase away from both clock edges
		#(clkPeriod / 4);
		data = prdata;
		err = pslverr;
		checkReady(addr);
		@(posedge clk);
	endtask

	task automatic hostWrite(input logic [execPkg::addrWidth-1:0] addr,
		input logic [execPkg::dataWidth-1:0] data);
		logic err;
		apbWrite(addr, data, err);
		if (err !== 1'b0)
		begin
			errorCount++;
			$display("unexpected slave error on a write to address %02h", addr);
		end
	endtask

	task automatic hostRead(input logic [execPkg::addrWidth-1:0] addr,
		output logic [execPkg::dataWidth-1:0] data);
		logic err;
		apbRead(addr, data, err);
		if (err !== 1'b0)
		begin
			errorCount++;
			$display("unexpected slave error on a read from address %02h", addr);
		end
	endtask

	function automatic logic [execPkg::addrWidth-1:0] regAddress(
		input logic [execPkg::regIdxWidth-1:0] idx);
		return execPkg::addrRegBase + {2'b00, idx, 2'b00};
	endfunction

	task automatic writeRegister(input logic [execPkg::regIdxWidth-1:0] idx,
		input logic [execPkg::dataWidth-1:0] value);
		hostWrite(regAddress(idx), value);
		shadowRegs[idx] = value;
	endtask

	// ======================================================================
	// Test runners
	// ======================================================================
	// Kind x clears the flags first, c keeps them from the test before,
	// n expects no register write at all
	task automatic runExec(input goldenLine t);
		logic [execPkg::regIdxWidth-1:0] rt;
		logic [execPkg::dataWidth-1:0]   word;
		rt = t.instr[11:8];
		if (t.kind != "c")
			hostWrite(execPkg::addrFlags, '0);
		hostWrite(execPkg::addrCtrl, t.ctrl);
		writeRegister(t.instr[15:12], t.aVal);
		writeRegister(t.instr[19:16], t.bVal);
		hostWrite(execPkg::addrInstr, t.instr);
		hostRead(execPkg::addrResult, word);
		checkWord(t.name, "result", t.expWord, word);
		hostRead(execPkg::addrFlags, word);
		checkFlags(t.name, t.expFlags, word[execPkg::flagCount-1:0]);
		if (t.kind == "n")
		begin
			for (int i = 0; i < execPkg::regCount; i++)
			begin
				hostRead(regAddress(execPkg::regIdxWidth'(i)), word);
				checkWord(t.name, "register", shadowRegs[i], word);
			end
		end
		else
		begin
			shadowRegs[rt] = t.expWord;
			hostRead(regAddress(rt), word);
			checkWord(t.name, "target", t.expWord, word);
		end
	endtask

	task automatic runTest(input goldenLine t);
		logic [execPkg::dataWidth-1:0] word;
		logic err;
		int errorsBefore;
		errorsBefore = errorCount;
		case (t.kind)
			"r":
			begin
				hostRead(t.aVal[execPkg::addrWidth-1:0], word);
				checkWord(t.name, "read", t.expWord, word);
			end
			"e":
			begin
				if (t.ctrl[0])
					apbWrite(t.aVal[execPkg::addrWidth-1:0], t.bVal, err);
				else
					apbRead(t.aVal[execPkg::addrWidth-1:0], word, err);
				checkErr(t.name, t.expWord[0], err);
			end
			"f":
			begin
				hostWrite(execPkg::addrFlags, '0);
				hostRead(execPkg::addrFlags, word);
				checkFlags(t.name, t.expFlags, word[execPkg::flagCount-1:0]);
			end
			"x", "c", "n": runExec(t);
			default:
			begin
				errorCount++;
				$display("test %s has an unknown kind %s", t.name, t.kind);
			end
		endcase
		$display("test %-14s %s", t.name, (errorCount == errorsBefore) ? "ok" : "failed");
	endtask

	task automatic loadGolden();
		int fd;
		int count;
		string line;
		logic [7:0] kindBuf;
		logic [8*32-1:0] nameBuf;
		goldenLine entry;
		fd = $fopen(goldenPath, "r");
		if (fd == 0)
		begin
			errorCount++;
			$display("cannot open the golden file %s", goldenPath);
			return;
		end
		while (!$feof(fd))
		begin
			line = "";
			if ($fgets(line, fd) == 0)
				break;
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			count = $sscanf(line, "%s %s %h %h %h %h %h %h", kindBuf, nameBuf, entry.ctrl,
				entry.aVal, entry.bVal, entry.instr, entry.expWord, entry.expFlags);
			if (count != 8)
			begin
				errorCount++;
				$display("golden line could not be parsed: %s", line);
				continue;
			end
			entry.kind = kindBuf;
			entry.name = $sformatf("%0s", nameBuf);
			tests.push_back(entry);
		end
		$fclose(fd);
	endtask

	// ======================================================================
	// Main sequence and watchdog
	// ======================================================================
	initial
	begin
		clk = 1'b0;
		arstN = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		for (int i = 0; i < execPkg::regCount; i++)
			shadowRegs[i] = '0;
		loadGolden();
		watchdogCycles = tests.size() * cyclesPerTest + spareCycles;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;
		foreach (tests[i])
			runTest(tests[i]);
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		$display("tests %0d, checks %0d, errors %0d", tests.size(), checkCount, errorCount);
		if (errorCount == 0 && tests.size() > 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	initial
	begin
		wait (watchdogCycles > 0);
		repeat (watchdogCycles) @(posedge clk);
		$display("timeout, the run did not finish within %0d cycles", watchdogCycles);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== test/exec_golden.dat ====
# kind name ctrl aVal bVal instr expWord expFlags (values in hex)
# kinds: r read, e slave error, f flag clear, x exec, c exec keeping flags, n exec no write
r rstReg0        0 00000040 00000000 00000000 00000000 00
r rstReg15       0 0000007C 00000000 00000000 00000000 00
r rstResult      0 00000004 00000000 00000000 00000000 00
r rstFlags       0 00000008 00000000 00000000 00000000 00
r rstCtrl        0 0000000C 00000000 00000000 00000000 00
# Register-register arithmetic and logic, R3 = R1 op R2
x addBasic       0 00000005 00000003 00021301 00000008 00
x addCarryOut    0 FFFFFFFF 00000001 00021301 00000000 03
c addNoCarry     0 00000001 00000001 00021301 00000002 00
x addOverflow    0 7FFFFFFF 00000001 00021301 80000000 0C
x addCarrySet    1 FFFFFFFF 00000002 00021301 00000001 01
c adcUse         1 00000010 00000020 00021301 00000031 00
x subBasic       0 0000000A 00000003 00021302 00000007 00
x subBorrow      0 00000003 00000005 00021302 FFFFFFFE 05
c sbcNoBorrow    1 0000000A 00000003 00021302 00000007 00
x sbcBorrow      1 0000000A 00000003 00021302 00000006 00
x subOverflow    0 80000000 00000001 00021302 7FFFFFFF 08
x andMask        0 F0F0F0F0 FF00FF00 00021303 F000F000 04
x orMerge        1 0F0F0000 000000F0 00021304 0F0F00F0 00
x eorSelf        0 12345678 12345678 00021305 00000000 02
# Shifts, rotates through carry, INC and DEC
x aslOut         0 80000001 00000000 00021310 00000002 01
x lsrOut         0 00000003 00000000 00021311 00000001 01
c rolIn          0 40000000 00000000 00021312 80000001 04
x rorZero        0 00000001 00000000 00021313 00000000 03
c rorIn          0 00000000 00000000 00021313 80000000 04
x incWrap        0 FFFFFFFF 00000000 00021314 00000000 03
x decWrap        0 00000000 00000000 00021315 FFFFFFFF 05
# Immediate forms, 12-bit signed immediate in bits 31..20
x addImmNeg      0 00000010 00000000 FFD21320 0000000D 01
x subImmNeg      0 00000010 00000000 FFF21321 00000011 01
x ldImmNeg       0 00000000 00000000 80021322 FFFFF800 04
x ldImmPos       0 00000000 00000000 7FF21322 000007FF 00
x addImmPos      0 FFFFFFF0 00000000 01021320 00000000 03
# Bit operations, compare and flag copy
x bmsBit         0 00000000 0000001F 00021330 80000000 04
x bmcBit         0 FFFFFFFF 00000024 00021331 FFFFFFEF 04
n cmpEqual       0 00000055 00000055 00021332 00000000 02
n cmpLess        1 80000000 00000001 00021332 7FFFFFFF 08
n cmpBorrow      0 00000001 00000002 00021332 FFFFFFFF 05
c tsrCopy        0 00000000 00000000 00021333 00000005 05
# Illegal opcode and flag clear
n illegalOp      0 00000000 00000000 000213FF 00000000 10
c illegalSticky  0 00000001 00000001 00021301 00000002 10
f flagClear      0 00000000 00000000 00000000 00000000 00
# Slave errors, ctrl is pwrite and expWord is the expected pslverr
e errUnmapped    0 00000010 00000000 00000000 00000001 00
e errResultWr    1 00000004 12345678 00000000 00000001 00
e errMisaligned  0 00000041 00000000 00000000 00000001 00
e okReg          0 00000044 00000000 00000000 00000000 00
e okCtrl         1 0000000C 00000000 00000000 00000000 00

// ==== tb.f ====
source/execPkg.sv
source/aluCore.sv
source/registerFile.sv
source/flagUnit.sv
source/apbExecUnit.sv
source/execTop.sv
test/execTb.sv

// ==== Makefile ====
TOP := execTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f tb.f --top-module $(TOP) -o V$(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "=== PASS ==="

lint:
	verilator --lint-only -Wall --timing -f tb.f --top-module execTop

clean:
	rm -rf obj_dir
